// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] inst_t;

	// major opcodes
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;

	// funct3, shared by reg-reg and reg-imm forms
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt = 7'b0100000;

	localparam word_t reset_pc = 32'h0000_0000;

	// pass_b forwards operand b, used by lui
	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
	} alu_op_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	// instruction bus
	typedef struct packed {
		logic valid;
		word_t addr;
	} ibus_req_t;

	typedef struct packed {
		logic data_ok;
		inst_t data;
	} ibus_resp_t;

	// stage registers
	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
		alu_op_t alu_op;
		word_t op_a;
		word_t op_b;
		reg_addr_t rd;
		logic write;
		logic illegal;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
		reg_addr_t rd;
		logic write;
		word_t result;
	} ex_wb_t;

	// one record per retired instruction
	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
		logic write;
		reg_addr_t rd;
		word_t data;
	} commit_t;

endpackage

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input isa_pkg::reg_addr_t waddr,
	input isa_pkg::word_t wdata,
	input isa_pkg::reg_addr_t raddr_a,
	input isa_pkg::reg_addr_t raddr_b,
	output isa_pkg::word_t rdata_a,
	output isa_pkg::word_t rdata_b,
	output isa_pkg::word_t [31:0] regs
);
	import isa_pkg::*;

	word_t [31:0] mem;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem <= '0;
		end else if (we && waddr != '0) begin
			mem[waddr] <= wdata;
		end
	end

	// same-cycle write is visible to decode
	always_comb begin
		rdata_a = mem[raddr_a];
		rdata_b = mem[raddr_b];
		if (we && waddr != '0 && waddr == raddr_a)
			rdata_a = wdata;
		if (we && waddr != '0 && waddr == raddr_b)
			rdata_b = wdata;
	end

	assign regs = mem;

	x0_zero: assert property (@(posedge clk) disable iff (rst) mem[0] == '0);

endmodule

`default_nettype wire

// ==== rtl/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch (
	input wire logic clk,
	input wire logic rst,
	input wire logic hold,
	output pipe_pkg::ibus_req_t ireq,
	input pipe_pkg::ibus_resp_t iresp,
	output logic advance,
	output pipe_pkg::if_id_t if_id,
	output isa_pkg::word_t pc
);
	import isa_pkg::*;

	word_t pc_q;
	logic req_on;

	// request stays up from the first cycle after reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			req_on <= 1'b0;
		else
			req_on <= 1'b1;
	end

	always_comb begin
		ireq.valid = req_on;
		ireq.addr = pc_q;
	end

	// the whole pipeline moves on a completed fetch
	assign advance = req_on & iresp.data_ok;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc_q <= reset_pc;
			if_id <= '0;
		end else if (advance && !hold) begin
			if_id.valid <= 1'b1;
			if_id.pc <= pc_q;
			if_id.inst <= iresp.data;
			pc_q <= pc_q + 32'd4;
		end
		// on hold the same address is fetched again
	end

	assign pc = pc_q;

	addr_stable: assert property (@(posedge clk) disable iff (rst)
		ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq.addr));

endmodule

`default_nettype wire

// ==== rtl/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
	input wire logic clk,
	input wire logic rst,
	input wire logic advance,
	input pipe_pkg::if_id_t if_id,
	output pipe_pkg::id_ex_t id_ex_cur,
	input pipe_pkg::ex_wb_t ex_wb_cur,
	input isa_pkg::word_t rdata_a,
	input isa_pkg::word_t rdata_b,
	output isa_pkg::reg_addr_t raddr_a,
	output isa_pkg::reg_addr_t raddr_b,
	output logic hold
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t imm_i;
	word_t imm_u;
	logic use_rs1;
	logic use_rs2;
	logic legal;
	alu_op_t alu_op;
	logic hazard_a;
	logic hazard_b;
	id_ex_t id_ex_next;

	always_comb begin
		opcode = if_id.inst[6:0];
		rd = if_id.inst[11:7];
		funct3 = if_id.inst[14:12];
		rs1 = if_id.inst[19:15];
		rs2 = if_id.inst[24:20];
		funct7 = if_id.inst[31:25];
		imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
		imm_u = {if_id.inst[31:12], 12'b0};
	end

	always_comb begin
		legal = 1'b1;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		alu_op = alu_add;
		case (opcode)
			opc_op: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				if (funct7 == f7_alt && funct3 == f3_add_sub) begin
					alu_op = alu_sub;
				end else if (funct7 == f7_base) begin
					case (funct3)
						f3_add_sub: alu_op = alu_add;
						f3_slt: alu_op = alu_slt;
						f3_xor: alu_op = alu_xor;
						f3_or: alu_op = alu_or;
						f3_and: alu_op = alu_and;
						default: legal = 1'b0;
					endcase
				end else begin
					legal = 1'b0;
				end
			end
			opc_op_imm: begin
				use_rs1 = 1'b1;
				case (funct3)
					f3_add_sub: alu_op = alu_add;
					f3_slt: alu_op = alu_slt;
					f3_xor: alu_op = alu_xor;
					f3_or: alu_op = alu_or;
					f3_and: alu_op = alu_and;
					// shifts and sltiu are not supported
					default: legal = 1'b0;
				endcase
			end
			opc_lui: alu_op = alu_pass_b;
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			use_rs1 = 1'b0;
			use_rs2 = 1'b0;
		end
	end

	assign raddr_a = rs1;
	assign raddr_b = rs2;

	// raw against the two younger stages, x0 never conflicts
	always_comb begin
		hazard_a = use_rs1 && rs1 != '0 &&
			((id_ex_cur.valid && id_ex_cur.write && id_ex_cur.rd == rs1) ||
			(ex_wb_cur.valid && ex_wb_cur.write && ex_wb_cur.rd == rs1));
		hazard_b = use_rs2 && rs2 != '0 &&
			((id_ex_cur.valid && id_ex_cur.write && id_ex_cur.rd == rs2) ||
			(ex_wb_cur.valid && ex_wb_cur.write && ex_wb_cur.rd == rs2));
		hold = if_id.valid && (hazard_a || hazard_b);
	end

	always_comb begin
		id_ex_next.valid = if_id.valid;
		id_ex_next.pc = if_id.pc;
		id_ex_next.inst = if_id.inst;
		id_ex_next.alu_op = alu_op;
		id_ex_next.op_a = use_rs1 ? rdata_a : '0;
		id_ex_next.op_b = (opcode == opc_op) ? rdata_b :
			(opcode == opc_lui) ? imm_u : imm_i;
		id_ex_next.rd = rd;
		id_ex_next.write = legal && rd != '0;
		id_ex_next.illegal = !legal;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			id_ex_cur <= '0;
		end else if (advance) begin
			if (hold)
				id_ex_cur <= '0;
			else
				id_ex_cur <= id_ex_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
	input wire logic clk,
	input wire logic rst,
	input wire logic advance,
	input pipe_pkg::id_ex_t id_ex,
	output pipe_pkg::ex_wb_t ex_wb
);
	import isa_pkg::*;

	word_t result;

	always_comb begin
		case (id_ex.alu_op)
			alu_add: result = id_ex.op_a + id_ex.op_b;
			alu_sub: result = id_ex.op_a - id_ex.op_b;
			alu_and: result = id_ex.op_a & id_ex.op_b;
			alu_or: result = id_ex.op_a | id_ex.op_b;
			alu_xor: result = id_ex.op_a ^ id_ex.op_b;
			// signed compare for slt and slti
			alu_slt: result = {31'b0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
			alu_pass_b: result = id_ex.op_b;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_wb <= '0;
		end else if (advance) begin
			ex_wb.valid <= id_ex.valid;
			ex_wb.pc <= id_ex.pc;
			ex_wb.inst <= id_ex.inst;
			ex_wb.rd <= id_ex.rd;
			ex_wb.write <= id_ex.write && !id_ex.illegal;
			ex_wb.result <= result;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback (
	input wire logic clk,
	input wire logic rst,
	input wire logic advance,
	input pipe_pkg::ex_wb_t ex_wb,
	output logic we,
	output isa_pkg::reg_addr_t waddr,
	output isa_pkg::word_t wdata,
	output pipe_pkg::commit_t commit
);
	import isa_pkg::*;

	word_t last_pc;
	logic seen;

	assign we = ex_wb.valid && ex_wb.write && advance;
	assign waddr = ex_wb.rd;
	assign wdata = ex_wb.result;

	// commit is a single-cycle pulse per retired instruction
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			commit <= '0;
		end else if (advance) begin
			commit.valid <= ex_wb.valid;
			commit.pc <= ex_wb.pc;
			commit.inst <= ex_wb.inst;
			commit.write <= ex_wb.write;
			commit.rd <= ex_wb.rd;
			commit.data <= ex_wb.result;
		end else begin
			commit.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_pc <= '0;
			seen <= 1'b0;
		end else if (commit.valid) begin
			last_pc <= commit.pc;
			seen <= 1'b1;
		end
	end

	no_double_commit: assert property (@(posedge clk) disable iff (rst)
		commit.valid && seen |-> commit.pc != last_pc);

endmodule

`default_nettype wire

// ==== rtl/riscv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
	input wire logic clk,
	input wire logic rst,
	output pipe_pkg::ibus_req_t ireq,
	input pipe_pkg::ibus_resp_t iresp,
	output pipe_pkg::commit_t commit,
	output isa_pkg::word_t [31:0] regs
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic advance;
	logic hold;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_wb_t ex_wb;

	logic we;
	reg_addr_t waddr;
	word_t wdata;
	reg_addr_t raddr_a;
	reg_addr_t raddr_b;
	word_t rdata_a;
	word_t rdata_b;

	regfile regfile_i (
		.clk(clk),
		.rst(rst),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.regs(regs)
	);

	// fetch also owns the global advance
	fetch fetch_i (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.ireq(ireq),
		.iresp(iresp),
		.advance(advance),
		.if_id(if_id),
		.pc()
	);

	decode decode_i (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.if_id(if_id),
		.id_ex_cur(id_ex),
		.ex_wb_cur(ex_wb),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.hold(hold)
	);

	execute execute_i (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.id_ex(id_ex),
		.ex_wb(ex_wb)
	);

	writeback writeback_i (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.ex_wb(ex_wb),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.commit(commit)
	);

endmodule

`default_nettype wire

// ==== tests/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int clk_period = 100;
	localparam int rand_seed = 32'h4920_e677;
	localparam int max_latency = 3;
	localparam int max_prog = 112;
	localparam int max_commit = 32;
	// word offsets of the sections in the data file
	localparam int prog_base = 'h10;
	localparam int commit_base = 'h80;
	localparam int regs_base = 'h100;
	localparam inst_t nop_inst = 32'h0000_0013;

	typedef struct packed {
		word_t pc;
		logic write;
		reg_addr_t rd;
		word_t data;
	} exp_commit_t;

	logic clk;
	logic rst;
	ibus_req_t ireq;
	ibus_resp_t iresp;
	commit_t commit;
	word_t [31:0] regs;

	word_t raw [0:regs_base + 31];
	inst_t prog_mem [0:max_prog - 1];
	exp_commit_t exp_commits [0:max_commit - 1];
	word_t exp_regs [0:31];
	int n_prog;
	int n_commit;
	logic loaded;
	integer seed;
	int waited;
	int delay;

	riscv_core dut_i (
		.clk(clk),
		.rst(rst),
		.ireq(ireq),
		.iresp(iresp),
		.commit(commit),
		.regs(regs)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// beyond the image the core runs into nops
	function automatic inst_t fetch_word(input word_t addr);
		if (addr[31:2] < n_prog)
			return prog_mem[addr[31:2]];
		return nop_inst;
	endfunction

	// instruction memory, answers after 0 to 3 extra wait cycles
	always @(posedge clk) begin
		if (rst || iresp.data_ok) begin
			iresp <= '0;
			waited = 0;
			delay = $unsigned($random(seed)) % (max_latency + 1);
		end else if (ireq.valid) begin
			if (waited < delay) begin
				waited = waited + 1;
			end else begin
				iresp.data_ok <= 1'b1;
				iresp.data <= fetch_word(ireq.addr);
			end
		end
	end

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "run stopped after an error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else begin
			$display("FAIL time %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic load_tests();
		int i;
		int base;
		$readmemh("tests/core_tests.txt", raw);
		n_prog = raw[0];
		n_commit = raw[1];
		if (n_prog < 1 || n_prog > max_prog || n_commit < 1 || n_commit > max_commit) begin
			$display("the test data file holds no usable program length or commit count");
			stop_with_failure();
		end
		for (i = 0; i < n_prog; i++)
			prog_mem[i] = raw[prog_base + i];
		for (i = 0; i < n_commit; i++) begin
			base = commit_base + 4 * i;
			exp_commits[i].pc = raw[base];
			exp_commits[i].write = raw[base + 1][0];
			exp_commits[i].rd = raw[base + 2][4:0];
			exp_commits[i].data = raw[base + 3];
		end
		for (i = 0; i < 32; i++)
			exp_regs[i] = raw[regs_base + i];
	endtask

	task automatic check_commit(input int idx);
		exp_commit_t e;
		e = exp_commits[idx];
		check_word("commit.pc", commit.pc, e.pc);
		check_word("commit.inst", commit.inst, fetch_word(e.pc));
		check_word("commit.write", {31'b0, commit.write}, {31'b0, e.write});
		// rd and data only matter on a register write
		if (e.write) begin
			check_word("commit.rd", {27'b0, commit.rd}, {27'b0, e.rd});
			check_word("commit.data", commit.data, e.data);
		end
	endtask

	initial begin
		wait (loaded === 1'b1);
		repeat ((n_commit + 10) * 8) @(posedge clk);
		$display("timeout: the core did not retire all expected instructions in time");
		stop_with_failure();
	end

	initial begin
		int i;
		int r;
		rst = 1'b1;
		iresp = '0;
		loaded = 1'b0;
		seed = rand_seed;
		load_tests();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// commit is a one-cycle pulse, sampled mid-cycle
		for (i = 0; i < n_commit; i++) begin
			@(negedge clk);
			while (commit.valid !== 1'b1)
				@(negedge clk);
			check_commit(i);
		end
		for (r = 0; r < 32; r++)
			check_word($sformatf("regs[%0d]", r), regs[r], exp_regs[r]);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/core_tests.txt ====
// @000 program length and commit count, @010 program words,
// @080 expected commits as pc write rd data, @100 expected final x0..x31
@000
00000012 00000012
@010
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
002081b3 // add x3, x1, x2
40208233 // sub x4, x1, x2
0020f2b3 // and x5, x1, x2
0020e333 // or x6, x1, x2
0020c3b3 // xor x7, x1, x2
00112433 // slt x8, x2, x1
0020a4b3 // slt x9, x1, x2
fff12513 // slti x10, x2, -1
123455b7 // lui x11, 0x12345
6785e613 // ori x12, x11, 0x678
0ff67693 // andi x13, x12, 0xff
fff6c713 // xori x14, x13, -1
00708013 // addi x0, x1, 7
ffffffff // unknown encoding
003707b3 // add x15, x14, x3
0007a813 // slti x16, x15, 0
@080
00000000 1 01 00000005
00000004 1 02 fffffffd
00000008 1 03 00000002
0000000c 1 04 00000008
00000010 1 05 00000005
00000014 1 06 fffffffd
00000018 1 07 fffffff8
0000001c 1 08 00000001
00000020 1 09 00000000
00000024 1 0a 00000001
00000028 1 0b 12345000
0000002c 1 0c 12345678
00000030 1 0d 00000078
00000034 1 0e ffffff87
00000038 0 00 00000000
0000003c 0 00 00000000
00000040 1 0f ffffff89
00000044 1 10 00000001
@100
00000000 00000005 fffffffd 00000002 00000008 00000005 fffffffd fffffff8
00000001 00000000 00000001 12345000 12345678 00000078 ffffff87 ffffff89
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// ==== files.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/regfile.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/writeback.sv
rtl/riscv_core.sv
tests/tb_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - rtl/isa_pkg.sv
  - rtl/pipe_pkg.sv
  - rtl/regfile.sv
  - rtl/fetch.sv
  - rtl/decode.sv
  - rtl/execute.sv
  - rtl/writeback.sv
  - rtl/riscv_core.sv
  - target: test
    files:
      - tests/tb_core.sv
